// ==== lane_seq_defines.svh ====
`ifndef LANE_SEQ_DEFINES_SVH
`define LANE_SEQ_DEFINES_SVH

////////////////////////////////////////////////////////////////////////////
// Lane array geometry
////////////////////////////////////////////////////////////////////////////

// Number of vector lanes
`define LS_VLANE_NUM 8

// Words in each lane VRF
`define LS_MEM_DEPTH 512

// Largest element count a single lane can hold
`define LS_MAX_VL_PER_LANE 256

////////////////////////////////////////////////////////////////////////////
// Register file ports
////////////////////////////////////////////////////////////////////////////

`define LS_RPORT_NUM 2    // vs1 and vs2

`endif

// ==== lane_seq_isa_pkg.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

package lane_seq_isa_pkg;

    // Instruction kinds as encoded by the issue stage
    typedef enum logic [2:0] {
        NORMAL = 3'd0,    // Read then write after delay
        STORE  = 3'd2,    // Read only
        LOAD   = 3'd4     // Write from load beats
    } inst_kind_t;

    // Element width of an operand
    typedef enum logic [1:0] {
        EW_BYTE = 2'd0,
        EW_HALF = 2'd1,
        EW_WORD = 2'd2
    } ewidth_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        IDLE,
        DISPATCH,      // Counters get their start addresses
        NORMAL_RUN,
        STORE_RUN,
        LOAD_RUN
    } seq_state_t;

    // Total vector length over all lanes
    typedef logic [$clog2(`LS_VLANE_NUM * `LS_MAX_VL_PER_LANE) - 1:0] vl_t;

    // Element count inside one lane, also used for the instruction delay
    typedef logic [$clog2(`LS_MAX_VL_PER_LANE):0] elem_cnt_t;

endpackage

`default_nettype wire

// ==== lane_seq_vrf_pkg.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

package lane_seq_vrf_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Addressing
    ////////////////////////////////////////////////////////////////////////////

    // Word address inside one lane VRF
    typedef logic [$clog2(`LS_MEM_DEPTH) - 1:0] vrf_addr_t;

    // One address per read port
    typedef vrf_addr_t [`LS_RPORT_NUM - 1:0] raddr_arr_t;

    ////////////////////////////////////////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////////////////////////////////////////

    // Byte write enable of one 32 bit word
    typedef logic [3:0] bwen_t;

    // Byte enables for every lane
    typedef bwen_t [`LS_VLANE_NUM - 1:0] lane_bwen_t;

endpackage

`default_nettype wire

// ==== lane_seq_addr_cnt.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

module lane_seq_addr_cnt
    import lane_seq_isa_pkg::*;
    import lane_seq_vrf_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_i,
    input  wire vrf_addr_t start_addr_i,
    input  wire logic      load_i,     // Takes priority over en_i
    input  wire logic      en_i,       // One element per cycle
    input  wire ewidth_t   ewidth_i,
    output vrf_addr_t      addr_o
);

    localparam vrf_addr_t LAST_ADDR = vrf_addr_t'(`LS_MEM_DEPTH - 1);

    logic [1:0] sub_q;      // Element slot within the current word
    logic [1:0] sub_max;    // Last slot for this width

    // Elements packed into one word
    always_comb begin
        case (ewidth_i)
            EW_BYTE: sub_max = 2'd3;
            EW_HALF: sub_max = 2'd1;
            default: sub_max = 2'd0;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word address and sub counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            sub_q  <= '0;
            addr_o <= '0;
        end else if (load_i) begin
            sub_q  <= '0;
            addr_o <= start_addr_i;
        end else if (en_i) begin
            if (sub_q == sub_max) begin
                // Word filled so move to the next one
                sub_q  <= '0;
                addr_o <= (addr_o == LAST_ADDR) ? '0 : addr_o + 1'b1;
            end else begin
                sub_q <= sub_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== lane_seq_bwen_gen.sv ====
`default_nettype none

module lane_seq_bwen_gen
    import lane_seq_isa_pkg::*;
    import lane_seq_vrf_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       en_i,
    input  wire logic [1:0] wdata_width_i,    // 1 byte, 2 halfword, 3 word
    output bwen_t           bwen_o
);

    logic [3:0] shift4_q;    // Byte lane pointer
    logic [1:0] shift2_q;    // Halfword pointer
    ewidth_t    width;
    bwen_t      pattern;

    // Write width code is one above the element width code
    assign width = ewidth_t'(wdata_width_i - 2'd1);

    ////////////////////////////////////////////////////////////////////////////
    // Rotation registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end else if (en_i) begin
            shift4_q <= {shift4_q[2:0], shift4_q[3]};
            shift2_q <= {shift2_q[0], shift2_q[1]};
        end else begin
            // Restart so every write begins at byte 0
            shift4_q <= 4'b0001;
            shift2_q <= 2'b01;
        end
    end

    always_comb begin
        case (width)
            EW_BYTE: pattern = shift4_q;
            EW_HALF: pattern = {{2{shift2_q[1]}}, {2{shift2_q[0]}}};
            EW_WORD: pattern = 4'b1111;
            default: pattern = 4'b0000;    // Width code 0 writes nothing
        endcase
    end

    assign bwen_o = en_i ? pattern : '0;

endmodule

`default_nettype wire

// ==== lane_seq_ctrl.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

module lane_seq_ctrl
    import lane_seq_isa_pkg::*;
    import lane_seq_vrf_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       start_i,
    output logic            ready_o,
    input  wire inst_kind_t inst_kind_i,
    input  wire vl_t        vl_i,
    input  wire ewidth_t    vsew_i,
    input  wire logic [1:0] wdata_width_i,
    input  wire elem_cnt_t  inst_delay_i,
    input  wire vrf_addr_t  vrf_starting_waddr_i,
    input  wire raddr_arr_t vrf_starting_raddr_i,
    input  wire logic       load_last_i,
    output vrf_addr_t       start_waddr_o,    // Latched start addresses
    output raddr_arr_t      start_raddr_o,
    output logic            cnt_load_o,
    output logic            raddr_en_o,
    output logic            waddr_en_o,
    output ewidth_t         rd_width_o,
    output ewidth_t         wr_width_o,
    output logic            bwen_en_o,
    output logic [1:0]      wdata_width_o,
    output logic            load_mode_o,
    output logic            vrf_ren_o,
    output logic            store_data_valid_o,
    output logic            ready_for_load_o,
    output logic            request_write_control_o,
    output logic            write_data_sel_o
);

    localparam int LANE_SHIFT = $clog2(`LS_VLANE_NUM);
    localparam int CNT_W      = $clog2(`LS_MAX_VL_PER_LANE) + 2;    // Delay plus length

    seq_state_t       state_q;
    logic [CNT_W-1:0] main_cnt_q;
    logic [CNT_W-1:0] cnt_nxt;
    logic [CNT_W-1:0] len_ext;
    logic [CNT_W-1:0] dly_ext;
    logic [CNT_W-1:0] normal_last;    // Final cycle of a normal run
    logic             accept;
    logic             len_nz;
    logic             read_done;
    logic             write_start;
    logic             write_done;
    elem_cnt_t        per_lane_len;

    // Latched instruction fields
    inst_kind_t kind_q;
    ewidth_t    vsew_q;
    logic [1:0] wdata_width_q;
    elem_cnt_t  delay_q;
    elem_cnt_t  len_q;

    // Run strobes
    logic rd_q;
    logic wr_q;
    logic store_q;
    logic load_q;

    // Elements per lane, rounded up
    assign per_lane_len = elem_cnt_t'(vl_i >> LANE_SHIFT)
                        + elem_cnt_t'(vl_i[LANE_SHIFT-1:0] != '0);

    assign accept      = start_i && ready_o;
    assign len_ext     = CNT_W'(len_q);
    assign dly_ext     = CNT_W'(delay_q);
    assign normal_last = dly_ext + len_ext;
    assign cnt_nxt     = main_cnt_q + 1'b1;
    assign len_nz      = (len_q != '0);
    assign read_done   = (cnt_nxt == len_ext);
    assign write_start = (cnt_nxt == dly_ext) && len_nz;
    assign write_done  = (cnt_nxt == normal_last);

    ////////////////////////////////////////////////////////////////////////////
    // Instruction latch
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (accept) begin
            kind_q        <= inst_kind_i;
            vsew_q        <= vsew_i;
            wdata_width_q <= wdata_width_i;
            delay_q       <= inst_delay_i;
            len_q         <= per_lane_len;
            start_waddr_o <= vrf_starting_waddr_i;
            start_raddr_o <= vrf_starting_raddr_i;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // FSM and main counter
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q    <= IDLE;
            ready_o    <= 1'b1;
            main_cnt_q <= '0;
            cnt_load_o <= 1'b0;
            rd_q       <= 1'b0;
            wr_q       <= 1'b0;
            store_q    <= 1'b0;
            load_q     <= 1'b0;
        end else begin
            cnt_load_o <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (accept) begin
                        state_q    <= DISPATCH;
                        ready_o    <= 1'b0;
                        cnt_load_o <= 1'b1;    // Counters load during dispatch
                        main_cnt_q <= '0;
                    end
                end
                DISPATCH: begin
                    case (kind_q)
                        NORMAL: begin
                            state_q <= NORMAL_RUN;
                            rd_q    <= len_nz;
                        end
                        STORE: begin
                            state_q <= STORE_RUN;
                            rd_q    <= len_nz;
                            store_q <= len_nz;
                        end
                        LOAD: begin
                            state_q <= LOAD_RUN;
                            load_q  <= 1'b1;
                        end
                        default: begin
                            state_q <= IDLE;    // Unknown kind
                            ready_o <= 1'b1;
                        end
                    endcase
                end
                NORMAL_RUN: begin
                    main_cnt_q <= cnt_nxt;
                    if (read_done) rd_q <= 1'b0;
                    if (write_start) wr_q <= 1'b1;    // Writes trail reads by the delay
                    if (write_done) wr_q <= 1'b0;
                    if (main_cnt_q == normal_last) begin
                        state_q <= IDLE;
                        ready_o <= 1'b1;
                    end
                end
                STORE_RUN: begin
                    main_cnt_q <= cnt_nxt;
                    if (read_done) begin
                        rd_q    <= 1'b0;
                        store_q <= 1'b0;
                    end
                    if (main_cnt_q == len_ext) begin
                        state_q <= IDLE;
                        ready_o <= 1'b1;
                    end
                end
                LOAD_RUN: begin
                    if (load_last_i) begin    // Last beat is still written
                        load_q  <= 1'b0;
                        state_q <= IDLE;
                        ready_o <= 1'b1;
                    end
                end
                default: begin
                    state_q <= IDLE;
                    ready_o <= 1'b1;
                end
            endcase
        end
    end

    // Datapath controls
    assign vrf_ren_o          = rd_q;
    assign raddr_en_o         = rd_q;
    assign store_data_valid_o = store_q;
    assign bwen_en_o          = wr_q;
    assign waddr_en_o         = wr_q | load_q;
    assign wdata_width_o      = wdata_width_q;

    // Load side strobes
    assign load_mode_o             = load_q;
    assign ready_for_load_o        = load_q;
    assign request_write_control_o = load_q;
    assign write_data_sel_o        = load_q;

    // Stores read whole words and loads write whole words
    assign rd_width_o = (kind_q == STORE) ? EW_WORD : vsew_q;
    assign wr_width_o = (kind_q == LOAD) ? EW_WORD : ewidth_t'(wdata_width_q - 2'd1);

endmodule

`default_nettype wire

// ==== lane_seq_top.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

module lane_seq_top
    import lane_seq_isa_pkg::*;
    import lane_seq_vrf_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       rst_i,
    input  wire logic       start_i,
    output logic            ready_o,
    input  wire inst_kind_t inst_kind_i,
    input  wire vl_t        vl_i,
    input  wire ewidth_t    vsew_i,
    input  wire logic [1:0] wdata_width_i,    // 1 byte, 2 halfword, 3 word
    input  wire elem_cnt_t  inst_delay_i,
    input  wire vrf_addr_t  vrf_starting_waddr_i,
    input  wire raddr_arr_t vrf_starting_raddr_i,
    input  wire logic       load_last_i,
    input  wire lane_bwen_t load_bwen_i,
    output logic            vrf_ren_o,
    output raddr_arr_t      vrf_raddr_o,      // 0 is vs1, 1 is vs2
    output vrf_addr_t       vrf_waddr_o,
    output lane_bwen_t      vrf_bwen_o,
    output logic            store_data_valid_o,
    output logic            ready_for_load_o,
    output logic            request_write_control_o,
    output logic            write_data_sel_o
);

    vrf_addr_t  start_waddr;
    raddr_arr_t start_raddr;
    logic       cnt_load;
    logic       raddr_en;
    logic       waddr_en;
    logic       bwen_en;
    logic       load_mode;
    ewidth_t    rd_width;
    ewidth_t    wr_width;
    logic [1:0] wdata_width;
    bwen_t      gen_bwen;

    lane_seq_ctrl u_ctrl (
        .clk_i                   (clk_i),
        .rst_i                   (rst_i),
        .start_i                 (start_i),
        .ready_o                 (ready_o),
        .inst_kind_i             (inst_kind_i),
        .vl_i                    (vl_i),
        .vsew_i                  (vsew_i),
        .wdata_width_i           (wdata_width_i),
        .inst_delay_i            (inst_delay_i),
        .vrf_starting_waddr_i    (vrf_starting_waddr_i),
        .vrf_starting_raddr_i    (vrf_starting_raddr_i),
        .load_last_i             (load_last_i),
        .start_waddr_o           (start_waddr),
        .start_raddr_o           (start_raddr),
        .cnt_load_o              (cnt_load),
        .raddr_en_o              (raddr_en),
        .waddr_en_o              (waddr_en),
        .rd_width_o              (rd_width),
        .wr_width_o              (wr_width),
        .bwen_en_o               (bwen_en),
        .wdata_width_o           (wdata_width),
        .load_mode_o             (load_mode),
        .vrf_ren_o               (vrf_ren_o),
        .store_data_valid_o      (store_data_valid_o),
        .ready_for_load_o        (ready_for_load_o),
        .request_write_control_o (request_write_control_o),
        .write_data_sel_o        (write_data_sel_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Address counters
    ////////////////////////////////////////////////////////////////////////////

    lane_seq_addr_cnt u_waddr_cnt (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .start_addr_i (start_waddr),
        .load_i       (cnt_load),
        .en_i         (waddr_en),
        .ewidth_i     (wr_width),
        .addr_o       (vrf_waddr_o)
    );

    for (genvar p = 0; p < `LS_RPORT_NUM; p++) begin : g_rport
        lane_seq_addr_cnt u_raddr_cnt (
            .clk_i        (clk_i),
            .rst_i        (rst_i),
            .start_addr_i (start_raddr[p]),
            .load_i       (cnt_load),
            .en_i         (raddr_en),
            .ewidth_i     (rd_width),
            .addr_o       (vrf_raddr_o[p])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Byte enables
    ////////////////////////////////////////////////////////////////////////////

    lane_seq_bwen_gen u_bwen_gen (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .en_i          (bwen_en),
        .wdata_width_i (wdata_width),
        .bwen_o        (gen_bwen)
    );

    // Loads take per lane enables from the load unit
    always_comb begin
        for (int lane = 0; lane < `LS_VLANE_NUM; lane++) begin
            vrf_bwen_o[lane] = load_mode ? load_bwen_i[lane] : gen_bwen;
        end
    end

endmodule

`default_nettype wire

// ==== lane_seq_assert.sv ====
`default_nettype none

module lane_seq_assert
    import lane_seq_vrf_pkg::*;
(
    input wire logic       clk_i,
    input wire logic       rst_i,
    input wire logic       ready_o,
    input wire logic       vrf_ren_o,
    input wire lane_bwen_t vrf_bwen_o,
    input wire logic       store_data_valid_o,
    input wire logic       ready_for_load_o
);

    // Nothing is written while idle
    idle_no_write: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_o |-> (vrf_bwen_o == '0))
        else $error("byte enables active while the sequencer is idle");

    store_no_write: assert property (@(posedge clk_i) disable iff (!rst_i)
        store_data_valid_o |-> (vrf_bwen_o == '0))
        else $error("store data valid together with byte enables");

    // Loads never read the register file
    load_no_read: assert property (@(posedge clk_i) disable iff (!rst_i)
        ready_for_load_o |-> !vrf_ren_o)
        else $error("load ready together with a register file read");

endmodule

`default_nettype wire

// ==== lane_seq_tb.sv ====
`default_nettype none

`include "lane_seq_defines.svh"

module lane_seq_tb
    import lane_seq_isa_pkg::*;
    import lane_seq_vrf_pkg::*;
();

    localparam int MAX_CYCLES = 20 * (`LS_MAX_VL_PER_LANE + 64 + 8);

    typedef struct packed {
        inst_kind_t kind;
        elem_cnt_t  len;       // Elements per lane
        elem_cnt_t  delay;
        ewidth_t    vsew;
        logic [1:0] wwidth;
        vrf_addr_t  waddr;
        raddr_arr_t raddr;
    } inst_t;

    typedef struct packed {
        logic       ready;
        logic       ren;
        logic       store_valid;
        logic       load_on;      // All three load side strobes
        logic       raddr_chk;
        raddr_arr_t raddr;
        logic       waddr_chk;
        vrf_addr_t  waddr;
        lane_bwen_t bwen;
    } expect_t;

    logic       clk_i;
    logic       rst_i;
    logic       start_i;
    inst_kind_t inst_kind_i;
    vl_t        vl_i;
    ewidth_t    vsew_i;
    logic [1:0] wdata_width_i;
    elem_cnt_t  inst_delay_i;
    vrf_addr_t  vrf_starting_waddr_i;
    raddr_arr_t vrf_starting_raddr_i;
    logic       load_last_i;
    lane_bwen_t load_bwen_i;
    logic       ready_o;
    logic       vrf_ren_o;
    raddr_arr_t vrf_raddr_o;
    vrf_addr_t  vrf_waddr_o;
    lane_bwen_t vrf_bwen_o;
    logic       store_data_valid_o;
    logic       ready_for_load_o;
    logic       request_write_control_o;
    logic       write_data_sel_o;

    inst_t   cur_inst;
    expect_t exp_now;
    int      run_cycle = 0;    // Edges since the start was taken and 0 when idle
    int      last_beat = 0;    // Edge that sampled load_last_i
    int      cycles    = 0;
    int      checks    = 0;
    int      errors    = 0;

    lane_seq_top u_dut (
        .clk_i                   (clk_i),
        .rst_i                   (rst_i),
        .start_i                 (start_i),
        .ready_o                 (ready_o),
        .inst_kind_i             (inst_kind_i),
        .vl_i                    (vl_i),
        .vsew_i                  (vsew_i),
        .wdata_width_i           (wdata_width_i),
        .inst_delay_i            (inst_delay_i),
        .vrf_starting_waddr_i    (vrf_starting_waddr_i),
        .vrf_starting_raddr_i    (vrf_starting_raddr_i),
        .load_last_i             (load_last_i),
        .load_bwen_i             (load_bwen_i),
        .vrf_ren_o               (vrf_ren_o),
        .vrf_raddr_o             (vrf_raddr_o),
        .vrf_waddr_o             (vrf_waddr_o),
        .vrf_bwen_o              (vrf_bwen_o),
        .store_data_valid_o      (store_data_valid_o),
        .ready_for_load_o        (ready_for_load_o),
        .request_write_control_o (request_write_control_o),
        .write_data_sel_o        (write_data_sel_o)
    );

    bind lane_seq_top lane_seq_assert u_assert (
        .clk_i              (clk_i),
        .rst_i              (rst_i),
        .ready_o            (ready_o),
        .vrf_ren_o          (vrf_ren_o),
        .vrf_bwen_o         (vrf_bwen_o),
        .store_data_valid_o (store_data_valid_o),
        .ready_for_load_o   (ready_for_load_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Elements per lane, rounded up
    function automatic int lane_len(input int vl);
        return (vl + `LS_VLANE_NUM - 1) / `LS_VLANE_NUM;
    endfunction

    function automatic int sew_per_word(input ewidth_t sew);
        case (sew)
            EW_BYTE: return 4;
            EW_HALF: return 2;
            default: return 1;
        endcase
    endfunction

    function automatic int wwidth_per_word(input logic [1:0] wwidth);
        case (wwidth)
            2'd1:    return 4;
            2'd2:    return 2;
            default: return 1;
        endcase
    endfunction

    function automatic vrf_addr_t step_addr(input vrf_addr_t start, input int elem,
                                            input int per_word);
        return vrf_addr_t'((int'(start) + elem / per_word) % `LS_MEM_DEPTH);
    endfunction

    // Enable for write element n of a normal instruction
    function automatic bwen_t write_pattern(input logic [1:0] wwidth, input int n);
        case (wwidth)
            2'd1:    return bwen_t'(4'b0001 << (n % 4));
            2'd2:    return (n % 2 == 0) ? 4'b0011 : 4'b1100;
            2'd3:    return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    // Expected outputs seen at edge k after the start edge
    function automatic expect_t expected_at(input inst_t inst, input int k, input int last_k,
                                            input lane_bwen_t ld_bwen);
        expect_t e;
        int      len;
        int      j;
        int      w;
        e   = '0;
        len = int'(inst.len);
        j   = k - 2;                     // Read element
        w   = j - int'(inst.delay);      // Write element
        if (k == 0) begin
            e.ready = 1'b1;
            return e;
        end
        case (inst.kind)
            NORMAL: begin
                e.ready = (k >= int'(inst.delay) + len + 3);
                if (j >= 0 && j < len) begin
                    e.ren       = 1'b1;
                    e.raddr_chk = 1'b1;
                    for (int p = 0; p < `LS_RPORT_NUM; p++) begin
                        e.raddr[p] = step_addr(inst.raddr[p], j, sew_per_word(inst.vsew));
                    end
                end
                if (w >= 0 && w < len) begin
                    e.waddr_chk = 1'b1;
                    e.waddr     = step_addr(inst.waddr, w, wwidth_per_word(inst.wwidth));
                    for (int lane = 0; lane < `LS_VLANE_NUM; lane++) begin
                        e.bwen[lane] = write_pattern(inst.wwidth, w);
                    end
                end
            end
            STORE: begin
                e.ready = (k >= len + 3);
                if (j >= 0 && j < len) begin
                    e.ren         = 1'b1;
                    e.store_valid = 1'b1;
                    e.raddr_chk   = 1'b1;
                    for (int p = 0; p < `LS_RPORT_NUM; p++) begin
                        e.raddr[p] = step_addr(inst.raddr[p], j, 1);
                    end
                end
            end
            LOAD: begin
                e.ready = (last_k != 0) && (k > last_k);
                if (j >= 0 && !e.ready) begin
                    e.load_on   = 1'b1;
                    e.waddr_chk = 1'b1;
                    e.waddr     = step_addr(inst.waddr, j, 1);    // One word per beat
                    e.bwen      = ld_bwen;
                end
            end
            default: e.ready = (k >= 2);    // Unknown kinds leave dispatch for idle
        endcase
        return e;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checking
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_val(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act_v);
        checks++;
        assert (act_v === exp_v) else begin
            errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, exp_v, act_v);
        end
    endtask

    task automatic compare_outputs(input expect_t e);
        check_val("ready_o", 32'(e.ready), 32'(ready_o));
        check_val("vrf_ren_o", 32'(e.ren), 32'(vrf_ren_o));
        check_val("store_data_valid_o", 32'(e.store_valid), 32'(store_data_valid_o));
        check_val("ready_for_load_o", 32'(e.load_on), 32'(ready_for_load_o));
        check_val("request_write_control_o", 32'(e.load_on), 32'(request_write_control_o));
        check_val("write_data_sel_o", 32'(e.load_on), 32'(write_data_sel_o));
        check_val("vrf_bwen_o", 32'(e.bwen), 32'(vrf_bwen_o));
        if (e.raddr_chk) begin
            for (int p = 0; p < `LS_RPORT_NUM; p++) begin
                check_val($sformatf("vrf_raddr_o[%0d]", p), 32'(e.raddr[p]),
                          32'(vrf_raddr_o[p]));
            end
        end
        if (e.waddr_chk) check_val("vrf_waddr_o", 32'(e.waddr), 32'(vrf_waddr_o));
    endtask

    always @(posedge clk_i) begin
        if (!rst_i) begin
            run_cycle = 0;
            last_beat = 0;
            cur_inst  = '0;
        end else begin
            exp_now = expected_at(cur_inst, run_cycle, last_beat, load_bwen_i);
            compare_outputs(exp_now);
            if (cur_inst.kind == LOAD && run_cycle >= 2 && last_beat == 0 && load_last_i) begin
                last_beat = run_cycle;
            end
            if (exp_now.ready) begin
                run_cycle = 0;
                last_beat = 0;
                if (start_i) begin    // Taken only while idle
                    cur_inst.kind   = inst_kind_i;
                    cur_inst.len    = elem_cnt_t'(lane_len(int'(vl_i)));
                    cur_inst.delay  = inst_delay_i;
                    cur_inst.vsew   = vsew_i;
                    cur_inst.wwidth = wdata_width_i;
                    cur_inst.waddr  = vrf_starting_waddr_i;
                    cur_inst.raddr  = vrf_starting_raddr_i;
                    run_cycle       = 1;
                end
            end else begin
                run_cycle++;
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: sequencer still busy after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // Start pulse of one cycle with port 0 reading from base
    task automatic issue(input inst_kind_t kind, input int vl, input ewidth_t sew,
                         input logic [1:0] wwidth, input int delay, input vrf_addr_t base);
        inst_kind_i             = kind;
        vl_i                    = vl_t'(vl);
        vsew_i                  = sew;
        wdata_width_i           = wwidth;
        inst_delay_i            = elem_cnt_t'(delay);
        vrf_starting_waddr_i    = vrf_addr_t'($urandom);
        vrf_starting_raddr_i[0] = base;
        vrf_starting_raddr_i[1] = vrf_addr_t'($urandom);
        load_bwen_i             = lane_bwen_t'($urandom);    // Ignored outside loads
        start_i                 = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
    endtask

    task automatic wait_ready();
        while (!ready_o) begin
            @(negedge clk_i);
        end
    endtask

    // Loads write whole words whatever width comes with them
    task automatic run_load(input int beats);
        issue(LOAD, int'($urandom_range(2047, 1)), ewidth_t'($urandom_range(2, 0)),
              2'($urandom_range(3, 1)), 1, vrf_addr_t'($urandom));
        for (int b = 0; b < beats; b++) begin
            @(negedge clk_i);
            load_bwen_i = lane_bwen_t'($urandom);
            load_last_i = (b == beats - 1);    // Held low until the last beat
        end
        @(negedge clk_i);
        load_last_i = 1'b0;
        wait_ready();
    endtask

    initial begin
        void'($urandom(32'hdd93));
        rst_i                = 1'b0;
        start_i              = 1'b0;
        inst_kind_i          = NORMAL;
        vl_i                 = '0;
        vsew_i               = EW_BYTE;
        wdata_width_i        = 2'd3;
        inst_delay_i         = elem_cnt_t'(1);
        vrf_starting_waddr_i = '0;
        vrf_starting_raddr_i = '0;
        load_last_i          = 1'b0;
        load_bwen_i          = '0;
        repeat (2) @(negedge clk_i);
        rst_i = 1'b1;
        @(negedge clk_i);

        // Normal runs at byte, halfword and word writes
        for (int ww = 1; ww <= 3; ww++) begin
            repeat (2) begin
                issue(NORMAL, int'($urandom_range(2047, 1)), ewidth_t'($urandom_range(2, 0)),
                      2'(ww), int'($urandom_range(64, 1)), vrf_addr_t'($urandom));
                wait_ready();
            end
        end

        // Lengths that round up
        issue(NORMAL, 13, EW_BYTE, 2'd1, 1, vrf_addr_t'(511));
        wait_ready();
        issue(NORMAL, 9, EW_HALF, 2'd2, 3, vrf_addr_t'(100));
        wait_ready();

        repeat (3) begin
            issue(STORE, int'($urandom_range(2047, 1)), ewidth_t'($urandom_range(2, 0)),
                  2'($urandom_range(3, 1)), int'($urandom_range(64, 1)),
                  vrf_addr_t'($urandom));
            wait_ready();
        end

        repeat (4) run_load(int'($urandom_range(64, 1)));

        // Second start during a long run while read port 0 wraps
        issue(NORMAL, 2047, EW_WORD, 2'd3, 5, vrf_addr_t'(400));
        repeat (10) @(negedge clk_i);
        inst_kind_i = STORE;
        vl_i        = vl_t'(8);
        start_i     = 1'b1;
        @(negedge clk_i);
        start_i = 1'b0;
        wait_ready();

        repeat (4) @(negedge clk_i);
        $display("Checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== lane_seq_top.f ====
+incdir+.
lane_seq_isa_pkg.sv
lane_seq_vrf_pkg.sv
lane_seq_addr_cnt.sv
lane_seq_bwen_gen.sv
lane_seq_ctrl.sv
lane_seq_top.sv
lane_seq_assert.sv
lane_seq_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module lane_seq_tb \
    -f lane_seq_top.f -o lane_seq_sim \
    && ./obj_dir/lane_seq_sim > sim.log 2>&1 \
    || echo "Test failed" >> sim.log

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
